// ==== verilog/defs_pkg.sv ====
// Shared types and compressed-opcode patterns for the decode front
// Patterns are casez wildcards over the 16-bit RVC encoding

package defs_pkg;

  typedef logic [4:0]  reg_addr_t; // GPR index
  typedef logic [31:0] instr_t;    // Full instruction word
  typedef logic [15:0] cinstr_t;   // Compressed encoding

  // Quadrant 0
  localparam cinstr_t C_ADDI4SPN = 16'b000???????????00;
  localparam cinstr_t C_LW       = 16'b010???????????00;
  localparam cinstr_t C_SW       = 16'b110???????????00;

  // Quadrant 1
  localparam cinstr_t C_NOP      = 16'b000?00000?????01; // rd == x0, must precede C_ADDI
  localparam cinstr_t C_ADDI     = 16'b000???????????01;
  localparam cinstr_t C_JAL      = 16'b001???????????01; // RV32 only
  localparam cinstr_t C_LI       = 16'b010???????????01;
  localparam cinstr_t C_ADDI16SP = 16'b011?00010?????01; // rd == sp
  localparam cinstr_t C_SRLI     = 16'b100?00????????01;
  localparam cinstr_t C_SRAI     = 16'b100?01????????01;
  localparam cinstr_t C_ANDI     = 16'b100?10????????01;
  localparam cinstr_t C_SUB      = 16'b100011???00???01;
  localparam cinstr_t C_XOR      = 16'b100011???01???01;
  localparam cinstr_t C_OR       = 16'b100011???10???01;
  localparam cinstr_t C_AND      = 16'b100011???11???01;
  localparam cinstr_t C_J        = 16'b101???????????01;
  localparam cinstr_t C_BEQZ     = 16'b110???????????01;
  localparam cinstr_t C_BNEZ     = 16'b111???????????01;

  // Quadrant 2
  // The 100x group overlaps, so C_JR sits ahead of C_MV and
  // C_EBREAK ahead of C_JALR ahead of C_ADD in any casez
  localparam cinstr_t C_SLLI     = 16'b000???????????10;
  localparam cinstr_t C_LWSP     = 16'b010???????????10;
  localparam cinstr_t C_JR       = 16'b1000?????0000010; // rs2 == x0
  localparam cinstr_t C_MV       = 16'b1000??????????10;
  localparam cinstr_t C_EBREAK   = 16'b1001000000000010;
  localparam cinstr_t C_JALR     = 16'b1001?????0000010; // rs2 == x0
  localparam cinstr_t C_ADD      = 16'b1001??????????10;
  localparam cinstr_t C_SWSP     = 16'b110???????????10;

endpackage

// ==== verilog/rf_read_if.sv ====
// Two combinational read ports of the general-purpose register file

`timescale 1ns/1ns

interface rf_read_if #(
  parameter int DATA_W = 32
);

  defs_pkg::reg_addr_t rs1_addr;
  defs_pkg::reg_addr_t rs2_addr;
  logic [DATA_W-1:0]   rs1_data;
  logic [DATA_W-1:0]   rs2_data;

  modport reader (
    output rs1_addr, rs2_addr,
    input  rs1_data, rs2_data
  );

  modport file (
    input  rs1_addr, rs2_addr,
    output rs1_data, rs2_data
  );

endinterface

// ==== verilog/dec_comp_gpr.sv ====
// RVC register-field expansion
// Maps a 16-bit compressed encoding onto full rd/rs1/rs2 indices

`timescale 1ns/1ns

module dec_comp_gpr (
  input  logic                en,
  input  defs_pkg::cinstr_t   instr,
  output defs_pkg::reg_addr_t rd_addr,
  output defs_pkg::reg_addr_t rs1_addr,
  output defs_pkg::reg_addr_t rs2_addr
);

  localparam defs_pkg::reg_addr_t X0 = 5'd0;
  localparam defs_pkg::reg_addr_t RA = 5'd1;
  localparam defs_pkg::reg_addr_t SP = 5'd2;

  defs_pkg::reg_addr_t r_full;  // Bits 11:7
  defs_pkg::reg_addr_t r_p97;   // Prime register from bits 9:7
  defs_pkg::reg_addr_t r_p42;   // Prime register from bits 4:2
  defs_pkg::reg_addr_t r_62;    // Bits 6:2

  assign r_full = instr[11:7];
  assign r_p97  = {2'b01, instr[9:7]};
  assign r_p42  = {2'b01, instr[4:2]};
  assign r_62   = instr[6:2];

  always_comb begin
    rd_addr  = r_full;
    rs1_addr = X0;
    rs2_addr = X0;
    if (en) begin
      casez (instr)
        defs_pkg::C_ADDI4SPN: begin
          rd_addr  = r_p42;
          rs1_addr = SP;
        end
        defs_pkg::C_LW: begin
          rd_addr  = r_p42;
          rs1_addr = r_p97;
        end
        defs_pkg::C_SW: begin
          rs1_addr = r_p97;
          rs2_addr = r_p42;
        end
        defs_pkg::C_NOP:  rd_addr = X0;
        defs_pkg::C_ADDI: rs1_addr = r_full;
        defs_pkg::C_JAL:  rd_addr = RA; // Link to ra
        defs_pkg::C_LI:   rs1_addr = X0;
        defs_pkg::C_ADDI16SP: begin
          rd_addr  = SP;
          rs1_addr = SP;
        end
        defs_pkg::C_SRLI,
        defs_pkg::C_SRAI,
        defs_pkg::C_ANDI: begin
          rd_addr  = r_p97;
          rs1_addr = r_p97;
        end
        defs_pkg::C_SUB,
        defs_pkg::C_XOR,
        defs_pkg::C_OR,
        defs_pkg::C_AND: begin
          rd_addr  = r_p97;
          rs1_addr = r_p97;
          rs2_addr = r_p42;
        end
        defs_pkg::C_J: rd_addr = X0;
        defs_pkg::C_BEQZ,
        defs_pkg::C_BNEZ: begin
          rs1_addr = r_p97; // Compared against x0
          rs2_addr = X0;
        end
        defs_pkg::C_SLLI: rs1_addr = r_full;
        defs_pkg::C_LWSP: rs1_addr = SP;
        defs_pkg::C_JR: begin
          rd_addr  = X0;
          rs1_addr = r_full;
        end
        defs_pkg::C_MV: begin
          rs1_addr = X0;
          rs2_addr = r_62;
        end
        defs_pkg::C_EBREAK: begin
          rd_addr = X0;
        end
        defs_pkg::C_JALR: begin
          rd_addr  = RA;
          rs1_addr = r_full;
        end
        defs_pkg::C_ADD: begin
          rs1_addr = r_full;
          rs2_addr = r_62;
        end
        defs_pkg::C_SWSP: begin
          rs1_addr = SP;
          rs2_addr = r_62;
        end
        default: begin
          rs1_addr = X0; // Unlisted encodings, e.g. C.LUI
        end
      endcase
    end
  end

endmodule

// ==== verilog/decode_gpr.sv ====
// GPR address decode for 16- and 32-bit instruction words
// Compressed words go through the RVC expander, others use standard fields

`timescale 1ns/1ns

module decode_gpr (
  input  defs_pkg::instr_t    instr,
  output defs_pkg::reg_addr_t rd_addr,
  output defs_pkg::reg_addr_t rs1_addr,
  output defs_pkg::reg_addr_t rs2_addr
);

  logic                comp;
  defs_pkg::reg_addr_t c_rd_addr;
  defs_pkg::reg_addr_t c_rs1_addr;
  defs_pkg::reg_addr_t c_rs2_addr;

  assign comp = (instr[1:0] != 2'b11); // Low bits 11 mean a 32-bit word

  dec_comp_gpr u_comp (
    .en       (comp),
    .instr    (instr[15:0]),
    .rd_addr  (c_rd_addr),
    .rs1_addr (c_rs1_addr),
    .rs2_addr (c_rs2_addr)
  );

  assign rd_addr  = comp ? c_rd_addr  : instr[11:7];
  assign rs1_addr = comp ? c_rs1_addr : instr[19:15];
  assign rs2_addr = comp ? c_rs2_addr : instr[24:20];

endmodule

// ==== verilog/gpr_file.sv ====
// 32-entry general-purpose register file, x0 hardwired to zero
// Two combinational reads with same-cycle write-back bypass

`timescale 1ns/1ns

module gpr_file #(
  parameter int DATA_W = 32
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wb_en,
  input  defs_pkg::reg_addr_t wb_addr,
  input  logic [DATA_W-1:0]   wb_data,
  rf_read_if.file             rd
);

  logic [DATA_W-1:0] regs [1:31]; // No storage behind x0

  function automatic logic [DATA_W-1:0] read_port(input defs_pkg::reg_addr_t addr);
    logic [DATA_W-1:0] data;
    if (addr == '0) begin
      data = '0;
    end else if (wb_en && (wb_addr == addr)) begin
      data = wb_data; // Bypass
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 1; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (wb_en && (wb_addr != '0)) begin
      regs[wb_addr] <= wb_data;
    end
  end

  always_comb begin
    rd.rs1_data = read_port(rd.rs1_addr);
    rd.rs2_data = read_port(rd.rs2_addr);
  end

  // x0 reads as zero on both ports, even while a write targets it
  a_x0_zero : assert property (@(posedge clk) disable iff (!rst_n)
    ((rd.rs1_addr == '0) |-> (rd.rs1_data == '0)) and
    ((rd.rs2_addr == '0) |-> (rd.rs2_data == '0)))
    else $error("x0 read returned nonzero data");

endmodule

// ==== verilog/id_stage.sv ====
// Decode output stage
// Decodes register fields, reads the GPR file and registers the results

`timescale 1ns/1ns

module id_stage #(
  parameter int DATA_W = 32
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  defs_pkg::instr_t    instr,
  output logic                out_valid,
  output defs_pkg::reg_addr_t rd_addr,
  output defs_pkg::reg_addr_t rs1_addr,
  output defs_pkg::reg_addr_t rs2_addr,
  output logic [DATA_W-1:0]   rs1_data,
  output logic [DATA_W-1:0]   rs2_data,
  rf_read_if.reader           rd
);

  defs_pkg::reg_addr_t dec_rd_addr;
  defs_pkg::reg_addr_t dec_rs1_addr;
  defs_pkg::reg_addr_t dec_rs2_addr;

  decode_gpr u_decode (
    .instr    (instr),
    .rd_addr  (dec_rd_addr),
    .rs1_addr (dec_rs1_addr),
    .rs2_addr (dec_rs2_addr)
  );

  // Read the file in the decode cycle
  assign rd.rs1_addr = dec_rs1_addr;
  assign rd.rs2_addr = dec_rs2_addr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      rd_addr   <= '0;
      rs1_addr  <= '0;
      rs2_addr  <= '0;
      rs1_data  <= '0;
      rs2_data  <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin // Hold last values otherwise
        rd_addr  <= dec_rd_addr;
        rs1_addr <= dec_rs1_addr;
        rs2_addr <= dec_rs2_addr;
        rs1_data <= rd.rs1_data;
        rs2_data <= rd.rs2_data;
      end
    end
  end

  // No stale valid may leak out of reset
  a_valid_after_reset : assert property (@(posedge clk)
    $rose(rst_n) |-> !out_valid)
    else $error("out_valid high right after reset release");

endmodule

// ==== verilog/decode_rf_top.sv ====
// Register-operand front of the RV32IC decode stage
// Decoder and output stage reading a 32-entry GPR file with write-back

`timescale 1ns/1ns

module decode_rf_top #(
  parameter int DATA_W = 32
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  defs_pkg::instr_t    instr,
  input  logic                wb_en,
  input  defs_pkg::reg_addr_t wb_addr,
  input  logic [DATA_W-1:0]   wb_data,
  output logic                out_valid,
  output defs_pkg::reg_addr_t rd_addr,
  output defs_pkg::reg_addr_t rs1_addr,
  output defs_pkg::reg_addr_t rs2_addr,
  output logic [DATA_W-1:0]   rs1_data,
  output logic [DATA_W-1:0]   rs2_data
);

  rf_read_if #(.DATA_W(DATA_W)) rf_rd ();

  id_stage #(
    .DATA_W (DATA_W)
  ) u_id_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .instr     (instr),
    .out_valid (out_valid),
    .rd_addr   (rd_addr),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .rd        (rf_rd.reader)
  );

  gpr_file #(
    .DATA_W (DATA_W)
  ) u_gpr_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data),
    .rd      (rf_rd.file)
  );

endmodule

// ==== verification/tb_clk_gen.sv ====
// Free-running testbench clock

`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD = 4
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD / 2) clk = ~clk; // Half period per toggle

endmodule

// ==== verification/tb_decode_rf.sv ====
// Testbench for the decode_rf register-operand front
// Random instructions and write-backs checked against a reference model

`timescale 1ns/1ns

module tb_decode_rf;

  localparam int DATA_W  = 32;
  localparam int N_RESET = 16;
  localparam int N_IDLE  = 24;
  localparam int N_STD   = 200;
  localparam int N_RVC   = 600;
  localparam int N_WB    = 300;
  localparam int N_BYP   = 200;
  localparam int N_GAP   = 300;
  localparam int LIMIT   = 2 * (N_RESET + N_IDLE + N_STD + N_RVC + N_WB + N_BYP + N_GAP + 12);

  localparam int M_MIX = 0;
  localparam int M_STD = 1;
  localparam int M_RVC = 2;
  localparam int M_WB  = 3;
  localparam int M_BYP = 4;
  localparam int M_GAP = 5;

  logic                clk;
  logic                rst_n;
  logic                in_valid;
  logic [31:0]         instr;
  logic                wb_en;
  logic [4:0]          wb_addr;
  logic [DATA_W-1:0]   wb_data;
  logic                out_valid;
  logic [4:0]          rd_addr;
  logic [4:0]          rs1_addr;
  logic [4:0]          rs2_addr;
  logic [DATA_W-1:0]   rs1_data;
  logic [DATA_W-1:0]   rs2_data;

  // Expected output register contents
  logic                exp_valid;
  logic [4:0]          exp_rd;
  logic [4:0]          exp_rs1;
  logic [4:0]          exp_rs2;
  logic [DATA_W-1:0]   exp_d1;
  logic [DATA_W-1:0]   exp_d2;
  logic [DATA_W-1:0]   model_regs [0:31];

  integer seed = 32'hfa7bba9c;
  int     errors = 0;
  int     err_mark = 0;
  int     checks = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     cycles = 0;
  string  cur_test = "none";

  tb_clk_gen #(.PERIOD(4)) u_clk (.clk(clk));

  decode_rf_top #(.DATA_W(DATA_W)) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .instr     (instr),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data),
    .out_valid (out_valid),
    .rd_addr   (rd_addr),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data)
  );

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  // RVC register conventions, quadrant by quadrant
  task automatic model_decode(input logic [31:0] w, output logic [4:0] rd,
                              output logic [4:0] rs1, output logic [4:0] rs2);
    logic [4:0] full;
    logic [4:0] p97;
    logic [4:0] p42;
    logic [4:0] f62;
    logic [2:0] f3;
    full = w[11:7];
    p97  = 5'd8 + w[9:7];
    p42  = 5'd8 + w[4:2];
    f62  = w[6:2];
    f3   = w[15:13];
    rd   = full;
    rs1  = 5'd0;
    rs2  = 5'd0;
    if (w[1:0] == 2'b11) begin
      rs1 = w[19:15];
      rs2 = w[24:20];
    end else if (w[1:0] == 2'b00) begin
      if (f3 == 3'b000) begin
        rd  = p42;
        rs1 = 5'd2;
      end else if (f3 == 3'b010) begin
        rd  = p42;
        rs1 = p97;
      end else if (f3 == 3'b110) begin
        rs1 = p97;
        rs2 = p42;
      end
    end else if (w[1:0] == 2'b01) begin
      if (f3 == 3'b000) begin
        rs1 = full; // Also c.nop, which reads x0
      end else if (f3 == 3'b001) begin
        rd = 5'd1;
      end else if (f3 == 3'b011 && full == 5'd2) begin
        rs1 = 5'd2;
      end else if (f3 == 3'b100 && (w[11:10] != 2'b11 || !w[12])) begin
        rd  = p97;
        rs1 = p97;
        if (w[11:10] == 2'b11) rs2 = p42;
      end else if (f3 == 3'b101) begin
        rd = 5'd0;
      end else if (f3[2:1] == 2'b11) begin
        rs1 = p97;
      end
    end else begin
      if (f3 == 3'b000) begin
        rs1 = full;
      end else if (f3 == 3'b010) begin
        rs1 = 5'd2;
      end else if (f3 == 3'b110) begin
        rs1 = 5'd2;
        rs2 = f62;
      end else if (f3 == 3'b100) begin
        if (w[12] && w[11:2] == 10'd0) begin
          rd = 5'd0; // ebreak
        end else if (f62 == 5'd0) begin
          rd  = w[12] ? 5'd1 : 5'd0;
          rs1 = full;
        end else begin
          rs1 = w[12] ? full : 5'd0;
          rs2 = f62;
        end
      end
    end
  endtask

  function automatic logic [DATA_W-1:0] model_read(input logic [4:0] a, input logic we,
                                                   input logic [4:0] wa,
                                                   input logic [DATA_W-1:0] wd);
    if (a == 5'd0) return '0;
    if (we && wa == a) return wd;
    return model_regs[a];
  endfunction

  function automatic logic [31:0] gen_std();
    logic [31:0] w;
    w = $random(seed);
    w[1:0] = 2'b11;
    return w;
  endfunction

  // Forces the fields that select c.nop, c.addi16sp, c.jr/c.jalr and c.ebreak
  function automatic logic [31:0] gen_comp();
    logic [31:0] w;
    int          special;
    w = $random(seed);
    w[1:0] = {$random(seed)} % 3;
    special = {$random(seed)} % 6;
    case (special)
      1: w[11:7] = 5'd0;
      2: w[11:7] = 5'd2;
      3: w[6:2] = 5'd0;
      4: w[11:2] = 10'd0;
      default: w = w;
    endcase
    return w;
  endfunction

  task automatic compare_outputs();
    check("out_valid", exp_valid, out_valid);
    check("rd_addr", exp_rd, rd_addr);
    check("rs1_addr", exp_rs1, rs1_addr);
    check("rs2_addr", exp_rs2, rs2_addr);
    check("rs1_data", exp_d1, rs1_data);
    check("rs2_data", exp_d2, rs2_data);
  endtask

  task automatic run_test(input string name, input int n, input int mode);
    int                i;
    logic              v;
    logic              we;
    logic [31:0]       w;
    logic [4:0]        wa;
    logic [DATA_W-1:0] wd;
    logic [4:0]        d_rd;
    logic [4:0]        d_rs1;
    logic [4:0]        d_rs2;
    cur_test = name;
    for (i = 0; i <= n; i++) begin
      if (mode == M_STD) w = gen_std();
      else if (mode == M_RVC) w = gen_comp();
      else w = ({$random(seed)} % 2 == 0) ? gen_std() : gen_comp();
      model_decode(w, d_rd, d_rs1, d_rs2);
      v  = (i < n);
      we = 1'b0;
      wa = $random(seed);
      wd = $random(seed);
      if (mode == M_WB || mode == M_GAP) begin
        we = $random(seed);
        if ({$random(seed)} % 8 == 0) wa = 5'd0; // Attempted x0 write
      end else if (mode == M_BYP) begin
        we = 1'b1;
        wa = ({$random(seed)} % 2 == 0) ? d_rs1 : d_rs2;
      end
      if (mode == M_GAP) v = v && ({$random(seed)} % 3 != 0);
      if (i == n) we = 1'b0; // Drain cycle
      @(negedge clk);
      compare_outputs();
      in_valid = v;
      instr    = w;
      wb_en    = we;
      wb_addr  = wa;
      wb_data  = wd;
      exp_valid = v;
      if (v) begin
        exp_rd  = d_rd;
        exp_rs1 = d_rs1;
        exp_rs2 = d_rs2;
        exp_d1  = model_read(d_rs1, we, wa, wd);
        exp_d2  = model_read(d_rs2, we, wa, wd);
      end
      if (we && wa != 5'd0) model_regs[wa] = wd;
    end
    @(negedge clk);
    compare_outputs();
    tests_run++;
    if (errors != err_mark) tests_failed++;
    $display("test %-12s %0d cycles, %0d errors", name, n, errors - err_mark);
    err_mark = errors;
  endtask

  initial begin
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    instr     = '0;
    wb_en     = 1'b0;
    wb_addr   = '0;
    wb_data   = '0;
    exp_valid = 1'b0;
    exp_rd    = '0;
    exp_rs1   = '0;
    exp_rs2   = '0;
    exp_d1    = '0;
    exp_d2    = '0;
    for (int k = 0; k < 32; k++) model_regs[k] = '0;
    repeat (N_RESET) @(posedge clk);
    @(negedge clk);
    cur_test = "reset_state";
    compare_outputs(); // Reset values, still in reset
    rst_n = 1'b1;
    run_test("reset_state", N_IDLE, M_MIX);
    run_test("std_fields", N_STD, M_STD);
    run_test("rvc_fields", N_RVC, M_RVC);
    run_test("wb_readback", N_WB, M_WB);
    run_test("bypass", N_BYP, M_BYP);
    run_test("valid_gaps", N_GAP, M_GAP);
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

endmodule

// ==== decode_rf.f ====
verilog/defs_pkg.sv
verilog/rf_read_if.sv
verilog/dec_comp_gpr.sv
verilog/decode_gpr.sv
verilog/gpr_file.sv
verilog/id_stage.sv
verilog/decode_rf_top.sv
verification/tb_clk_gen.sv
verification/tb_decode_rf.sv

// ==== Bender.yml ====
package:
  name: decode_rf

sources:
  - files:
      - verilog/defs_pkg.sv
      - verilog/rf_read_if.sv
      - verilog/dec_comp_gpr.sv
      - verilog/decode_gpr.sv
      - verilog/gpr_file.sv
      - verilog/id_stage.sv
      - verilog/decode_rf_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_decode_rf.sv
